// File: project.f
logic/bfp_pkg.sv
logic/bfp_stage_if.sv
logic/group_aligner.sv
logic/signed_sum.sv
logic/sfp_pack.sv
logic/dft4_datapath.sv
logic/dft4_ctrl.sv
logic/bfp_dft4.sv
tb/tb_bfp_dft4.sv

// File: Bender.yml
package:
  name: bfp_dft4

sources:
  - logic/bfp_pkg.sv
  - logic/bfp_stage_if.sv
  - logic/group_aligner.sv
  - logic/signed_sum.sv
  - logic/sfp_pack.sv
  - logic/dft4_datapath.sv
  - logic/dft4_ctrl.sv
  - logic/bfp_dft4.sv
  - target: test
    files:
      - tb/tb_bfp_dft4.sv

// File: tb/tb_bfp_dft4.sv
// tb_bfp_dft4: table-driven and random testbench for the block-floating-point dft4 engine
`timescale 1ns/1ps
`default_nettype none

module tb_bfp_dft4;

  localparam int LOW_EXPAND      = 2;
  localparam int CLK_PERIOD      = 40;
  localparam int RST_CYCLES      = 16;
  localparam int N_TBL           = 4;
  localparam int N_RND           = 40;
  localparam int N_BUSY          = 2;  // slots used by the start-while-busy run
  localparam int WATCHDOG_CYCLES = (N_TBL + N_RND + N_BUSY) * 8 + RST_CYCLES;

  logic        clk;
  logic        rst;
  logic        start;
  logic [35:0] in_real;
  logic [35:0] in_imag;
  wire  [35:0] out_real;
  wire  [35:0] out_imag;
  wire         busy;
  wire         done;

  int          value_errors;
  int          protocol_errors;

  // words packed {x3, x2, x1, x0}
  string       tbl_name   [N_TBL];
  logic [35:0] tbl_in_re  [N_TBL];
  logic [35:0] tbl_in_im  [N_TBL];
  logic [35:0] tbl_out_re [N_TBL];
  logic [35:0] tbl_out_im [N_TBL];

  bfp_dft4 #(
    .LOW_EXPAND(LOW_EXPAND)
  ) dut (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .in_real (in_real),
    .in_imag (in_imag),
    .out_real(out_real),
    .out_imag(out_imag),
    .busy    (busy),
    .done    (done)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // one output word straight from X[k] = sum x[n] * (-j)^(nk)
  function automatic logic [8:0] model_word(input logic [35:0] re, input logic [35:0] im,
                                            input int k, input bit is_im);
    logic [8:0] ops [4];
    bit         neg [4];
    bit         take_im;
    bit         sub;
    int         q;
    int         blk_exp;
    int         mag;
    int         acc;
    int         r;
    int         e_out;
    logic       sgn;
    blk_exp = 0;
    acc     = 0;
    for (int n = 0; n < 4; n++) begin
      q       = (n * k) % 4;
      take_im = is_im ? (q % 2 == 0) : (q % 2 == 1);  // odd powers swap re and im
      sub     = is_im ? (q == 1 || q == 2) : (q >= 2);
      ops[n]  = take_im ? im[9*n +: 9] : re[9*n +: 9];
      neg[n]  = ops[n][8] ^ sub;
      if (int'(ops[n][7:4]) > blk_exp) begin
        blk_exp = int'(ops[n][7:4]);
      end
    end
    for (int n = 0; n < 4; n++) begin
      mag = int'(ops[n][3:0]) << LOW_EXPAND;
      mag = mag >> (blk_exp - int'(ops[n][7:4]));
      acc = neg[n] ? acc - mag : acc + mag;
    end
    sgn = (acc < 0);
    mag = sgn ? -acc : acc;
    r   = 0;
    while ((mag >> r) >= 16) begin
      r++;
    end
    if (r < LOW_EXPAND - blk_exp) begin
      r = LOW_EXPAND - blk_exp;
    end
    e_out = blk_exp - LOW_EXPAND + r;
    if (acc == 0) begin
      model_word = 9'h000;
    end else if (e_out > 15) begin
      model_word = {sgn, 4'hf, 4'hf};
    end else begin
      model_word = {sgn, 4'(e_out), 4'(mag >> r)};
    end
  endfunction

  function automatic logic [35:0] model_bus(input logic [35:0] re, input logic [35:0] im,
                                            input bit is_im);
    logic [35:0] bus;
    bus = '0;
    for (int k = 0; k < 4; k++) begin
      bus[9*k +: 9] = model_word(re, im, k, is_im);
    end
    return bus;
  endfunction

  task automatic set_entry(input int idx, input string name, input logic [35:0] re,
                           input logic [35:0] im, input logic [35:0] o_re,
                           input logic [35:0] o_im);
    tbl_name[idx]   = name;
    tbl_in_re[idx]  = re;
    tbl_in_im[idx]  = im;
    tbl_out_re[idx] = o_re;
    tbl_out_im[idx] = o_im;
  endtask

  task automatic load_table();
    set_entry(0, "equal_exp", {9'h023, 9'h023, 9'h023, 9'h023}, {9'h027, 9'h024, 9'h022, 9'h021},
              {9'h01a, 9'h000, 9'h11a, 9'h02c}, {9'h10c, 9'h118, 9'h10c, 9'h02e});
    set_entry(1, "mixed_exp", {9'h009, 9'h123, 9'h017, 9'h045}, {9'h12d, 9'h006, 9'h05b, 9'h132},
              {9'h159, 9'h02c, 9'h05f, 9'h03b}, {9'h118, 9'h15a, 9'h11e, 9'h059});
    set_entry(2, "saturate", {9'h1ff, 9'h0ff, 9'h0ff, 9'h0ff}, {9'h1ff, 9'h0ff, 9'h1ff, 9'h1ff},
              {9'h000, 9'h0ff, 9'h000, 9'h0ff}, {9'h000, 9'h0ff, 9'h1ff, 9'h1ff});
    set_entry(3, "exp_floor", {9'h000, 9'h003, 9'h002, 9'h001}, 36'h0,
              {9'h102, 9'h002, 9'h102, 9'h006}, {9'h002, 9'h000, 9'h102, 9'h000});
  endtask

  task automatic check_outputs(input string name, input logic [35:0] exp_re,
                               input logic [35:0] exp_im);
    assert (out_real === exp_re) else begin
      $display("Fail %s out_real expected %h actual %h", name, exp_re, out_real);
      value_errors++;
    end
    assert (out_imag === exp_im) else begin
      $display("Fail %s out_imag expected %h actual %h", name, exp_im, out_imag);
      value_errors++;
    end
  endtask

  task automatic run_transform(input string name, input logic [35:0] re, input logic [35:0] im,
                               input logic [35:0] exp_re, input logic [35:0] exp_im);
    int edges;
    @(posedge clk);
    #2;
    in_real = re;
    in_imag = im;
    start   = 1'b1;
    @(posedge clk);
    #2;
    start = 1'b0;
    edges = 1;
    while (!done && edges < 8) begin
      assert (busy) else begin
        $display("%s: busy low while the transform was running", name);
        protocol_errors++;
      end
      @(posedge clk);
      #2;
      edges++;
    end
    assert (done) else begin
      $display("%s: done never came after start", name);
      protocol_errors++;
    end
    assert (!done || edges == 4) else begin
      $display("%s: done came %0d edges after start instead of 4", name, edges);
      protocol_errors++;
    end
    check_outputs(name, exp_re, exp_im);
    @(posedge clk);
    #2;
    assert (!done) else begin
      $display("%s: done stayed high for more than one cycle", name);
      protocol_errors++;
    end
    assert (!busy) else begin
      $display("%s: busy stayed high after done", name);
      protocol_errors++;
    end
  endtask

  task automatic check_start_while_busy();
    int extra_done;
    extra_done = 0;
    @(posedge clk);
    #2;
    in_real = tbl_in_re[1];
    in_imag = tbl_in_im[1];
    start   = 1'b1;
    @(posedge clk);
    #2;
    start   = 1'b0;
    in_real = tbl_in_re[2];  // must not be captured
    in_imag = tbl_in_im[2];
    @(posedge clk);
    #2;
    start = 1'b1;  // lands in SUM
    @(posedge clk);
    #2;
    start = 1'b0;
    @(posedge clk);
    #2;
    assert (done) else begin
      $display("busy_start: done missing four edges after start");
      protocol_errors++;
    end
    check_outputs("busy_start", tbl_out_re[1], tbl_out_im[1]);
    repeat (8) begin
      @(posedge clk);
      #2;
      if (done) begin
        extra_done++;
      end
    end
    assert (extra_done == 0 && !busy) else begin
      $display("busy_start: start while busy began a second transform");
      protocol_errors++;
    end
    check_outputs("busy_start_hold", tbl_out_re[1], tbl_out_im[1]);
  endtask

  initial begin
    logic [35:0] rnd_re;
    logic [35:0] rnd_im;
    value_errors    = 0;
    protocol_errors = 0;
    rst             = 1'b0;
    start           = 1'b0;
    in_real         = '0;
    in_imag         = '0;
    void'($urandom(24));
    load_table();
    repeat (RST_CYCLES) @(posedge clk);
    #2;
    rst = 1'b1;
    assert (!busy && !done) else begin
      $display("reset: busy or done high after reset");
      protocol_errors++;
    end
    check_outputs("reset", 36'h0, 36'h0);
    for (int t = 0; t < N_TBL; t++) begin
      run_transform(tbl_name[t], tbl_in_re[t], tbl_in_im[t], tbl_out_re[t], tbl_out_im[t]);
    end
    check_start_while_busy();
    for (int t = 0; t < N_RND; t++) begin
      for (int n = 0; n < 4; n++) begin
        rnd_re[9*n +: 9] = 9'($urandom);
        rnd_im[9*n +: 9] = 9'($urandom);
      end
      run_transform($sformatf("random_%0d", t), rnd_re, rnd_im,
                    model_bus(rnd_re, rnd_im, 1'b0), model_bus(rnd_re, rnd_im, 1'b1));
    end
    $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles without the run finishing", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/bfp_dft4.sv
// bfp_dft4: block-floating-point four-point DFT engine with start/done handshake
`timescale 1ns/1ps
`default_nettype none

module bfp_dft4 #(
  parameter int LOW_EXPAND = bfp_pkg::LOW_EXPAND_DEF
) (
  input  wire                                      clk,
  input  wire                                      rst,
  input  wire                                      start,
  input  wire [bfp_pkg::WORD_W*bfp_pkg::N_PT-1:0]  in_real,
  input  wire [bfp_pkg::WORD_W*bfp_pkg::N_PT-1:0]  in_imag,
  output logic [bfp_pkg::WORD_W*bfp_pkg::N_PT-1:0] out_real,
  output logic [bfp_pkg::WORD_W*bfp_pkg::N_PT-1:0] out_imag,
  output logic                                     busy,
  output logic                                     done
);

  bfp_stage_if stage ();

  dft4_ctrl u_ctrl (
    .clk  (clk),
    .rst  (rst),
    .start(start),
    .stage(stage.ctrl),
    .busy (busy),
    .done (done)
  );

  dft4_datapath #(
    .LOW_EXPAND(LOW_EXPAND)
  ) u_datapath (
    .clk     (clk),
    .rst     (rst),
    .in_real (in_real),
    .in_imag (in_imag),
    .stage   (stage.dp),
    .out_real(out_real),
    .out_imag(out_imag)
  );

endmodule

`default_nettype wire

// File: logic/dft4_ctrl.sv
// dft4_ctrl: sequences capture, align, sum and pack for one transform, with busy and done
`timescale 1ns/1ps
`default_nettype none

module dft4_ctrl (
  input  wire       clk,
  input  wire       rst,
  input  wire       start,
  bfp_stage_if.ctrl stage,
  output logic      busy,
  output logic      done
);

  bfp_pkg::dft_state_e state;
  bfp_pkg::dft_state_e state_nx;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state <= bfp_pkg::IDLE;
    end else begin
      state <= state_nx;
    end
  end

  always_comb begin
    state_nx = state;
    case (state)
      bfp_pkg::IDLE: begin
        if (start) begin
          state_nx = bfp_pkg::ALIGN;
        end
      end
      bfp_pkg::ALIGN: state_nx = bfp_pkg::SUM;
      bfp_pkg::SUM:   state_nx = bfp_pkg::PACK;
      bfp_pkg::PACK:  state_nx = bfp_pkg::DONE;
      bfp_pkg::DONE:  state_nx = bfp_pkg::IDLE;
      default:        state_nx = bfp_pkg::IDLE;
    endcase
  end

  // start only counts in idle
  assign stage.capture_en = (state == bfp_pkg::IDLE) && start;
  assign stage.align_en   = (state == bfp_pkg::ALIGN);
  assign stage.sum_en     = (state == bfp_pkg::SUM);
  assign stage.pack_en    = (state == bfp_pkg::PACK);

  assign busy = (state != bfp_pkg::IDLE);
  assign done = (state == bfp_pkg::DONE);

  done_single_cycle: assert property (
    @(posedge clk) disable iff (!rst) done |=> !done
  );

  // output words are loaded the cycle before done shows
  pack_then_done: assert property (
    @(posedge clk) disable iff (!rst) stage.pack_en |=> done
  );

endmodule

`default_nettype wire

// File: logic/dft4_datapath.sv
// dft4_datapath: pipeline registers and arithmetic of the block-floating-point four-point DFT
`timescale 1ns/1ps
`default_nettype none

module dft4_datapath #(
  parameter int LOW_EXPAND = bfp_pkg::LOW_EXPAND_DEF
) (
  input  wire                                       clk,
  input  wire                                       rst,
  input  wire [bfp_pkg::WORD_W*bfp_pkg::N_PT-1:0]   in_real,
  input  wire [bfp_pkg::WORD_W*bfp_pkg::N_PT-1:0]   in_imag,
  bfp_stage_if.dp                                   stage,
  output logic [bfp_pkg::WORD_W*bfp_pkg::N_PT-1:0]  out_real,
  output logic [bfp_pkg::WORD_W*bfp_pkg::N_PT-1:0]  out_imag
);

  localparam int TERM_W = bfp_pkg::MAN_W + LOW_EXPAND + 1;
  localparam int ACC_W  = bfp_pkg::MAN_W + LOW_EXPAND + 3;
  localparam int N_PT   = bfp_pkg::N_PT;
  localparam int N_GRP  = bfp_pkg::N_GRP;
  localparam int N_OUT  = bfp_pkg::N_OUT;
  localparam int WORD_W = bfp_pkg::WORD_W;

  bfp_pkg::sfp_t              samp_q    [2][N_PT];  // [imag][index]
  bfp_pkg::sfp_t              grp_ops   [N_GRP][N_PT];
  logic signed [TERM_W-1:0]   term_d    [N_GRP][N_PT];
  logic signed [TERM_W-1:0]   term_q    [N_GRP][N_PT];
  logic [bfp_pkg::EXP_W-1:0]  max_exp_d [N_GRP];
  logic [bfp_pkg::EXP_W-1:0]  max_exp_q [N_GRP];
  logic signed [ACC_W-1:0]    sum_d     [N_OUT];
  logic signed [ACC_W-1:0]    sum_q     [N_OUT];
  logic [bfp_pkg::EXP_W-1:0]  sum_exp_q [N_OUT];
  bfp_pkg::sfp_t              word_d    [N_OUT];

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int n = 0; n < N_PT; n++) begin
        samp_q[0][n] <= '0;
        samp_q[1][n] <= '0;
      end
    end else if (stage.capture_en) begin
      for (int n = 0; n < N_PT; n++) begin
        samp_q[0][n] <= in_real[n*WORD_W +: WORD_W];
        samp_q[1][n] <= in_imag[n*WORD_W +: WORD_W];
      end
    end
  end

  for (genvar g = 0; g < N_GRP; g++) begin : g_group
    for (genvar p = 0; p < N_PT; p++) begin : g_route
      assign grp_ops[g][p] = samp_q[bfp_pkg::GROUP_SEL[g][p].imag][bfp_pkg::GROUP_SEL[g][p].idx];
    end

    group_aligner #(
      .LOW_EXPAND(LOW_EXPAND)
    ) u_align (
      .operands(grp_ops[g]),
      .max_exp (max_exp_d[g]),
      .terms   (term_d[g])
    );
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int g = 0; g < N_GRP; g++) begin
        max_exp_q[g] <= '0;
        for (int p = 0; p < N_PT; p++) begin
          term_q[g][p] <= '0;
        end
      end
    end else if (stage.align_en) begin
      max_exp_q <= max_exp_d;
      term_q    <= term_d;
    end
  end

  for (genvar o = 0; o < N_OUT; o++) begin : g_out
    signed_sum #(
      .LOW_EXPAND(LOW_EXPAND)
    ) u_sum (
      .terms   (term_q[bfp_pkg::TERM_SIGN[o].grp]),
      .sub_mask(bfp_pkg::TERM_SIGN[o].sub),
      .sum     (sum_d[o])
    );

    sfp_pack #(
      .LOW_EXPAND(LOW_EXPAND)
    ) u_pack (
      .sum    (sum_q[o]),
      .max_exp(sum_exp_q[o]),
      .word   (word_d[o])
    );
  end

  // block exponent follows its sum
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int o = 0; o < N_OUT; o++) begin
        sum_q[o]     <= '0;
        sum_exp_q[o] <= '0;
      end
    end else if (stage.sum_en) begin
      for (int o = 0; o < N_OUT; o++) begin
        sum_q[o]     <= sum_d[o];
        sum_exp_q[o] <= max_exp_q[bfp_pkg::TERM_SIGN[o].grp];
      end
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      out_real <= '0;
      out_imag <= '0;
    end else if (stage.pack_en) begin
      for (int k = 0; k < N_PT; k++) begin
        out_real[k*WORD_W +: WORD_W] <= word_d[k];
        out_imag[k*WORD_W +: WORD_W] <= word_d[k+N_PT];  // imag outputs after the real ones
      end
    end
  end

  // a new capture would overwrite samples still being aligned
  no_capture_in_align: assert property (
    @(posedge clk) disable iff (!rst) !(stage.align_en && stage.capture_en)
  );

endmodule

`default_nettype wire

// File: logic/sfp_pack.sv
// sfp_pack: normalises a signed block sum and packs it into a saturating 9-bit sample word
`timescale 1ns/1ps
`default_nettype none

module sfp_pack #(
  parameter int LOW_EXPAND = bfp_pkg::LOW_EXPAND_DEF
) (
  input  wire signed [bfp_pkg::MAN_W+LOW_EXPAND+2:0] sum,
  input  wire [bfp_pkg::EXP_W-1:0]                   max_exp,
  output bfp_pkg::sfp_t                              word
);

  localparam int ACC_W   = bfp_pkg::MAN_W + LOW_EXPAND + 3;
  localparam int MAN_LIM = 1 << bfp_pkg::MAN_W;
  localparam int EXP_MAX = (1 << bfp_pkg::EXP_W) - 1;

  logic [ACC_W-1:0] mag;
  int               shift;
  int               exp_val;

  assign mag = sum[ACC_W-1] ? ACC_W'(-sum) : ACC_W'(sum);

  always_comb begin
    shift = 0;
    for (int k = 0; k < ACC_W; k++) begin
      if ((mag >> shift) >= MAN_LIM) begin
        shift = shift + 1;
      end
    end
    // exponent floor at zero
    if (shift < LOW_EXPAND - int'(max_exp)) begin
      shift = LOW_EXPAND - int'(max_exp);
    end
    exp_val = int'(max_exp) - LOW_EXPAND + shift;
  end

  always_comb begin
    word      = '0;
    word.sign = sum[ACC_W-1];
    if (mag == '0) begin
      word = '0;
    end else if (exp_val > EXP_MAX) begin
      word.exp = '1;  // saturate, sign kept
      word.man = '1;
    end else begin
      word.exp = bfp_pkg::EXP_W'(exp_val);
      word.man = bfp_pkg::MAN_W'(mag >> shift);
    end
  end

endmodule

`default_nettype wire

// File: logic/signed_sum.sv
// signed_sum: applies one output's subtract pattern and adds the four aligned terms
`timescale 1ns/1ps
`default_nettype none

module signed_sum #(
  parameter int LOW_EXPAND = bfp_pkg::LOW_EXPAND_DEF
) (
  input  wire signed [bfp_pkg::MAN_W+LOW_EXPAND:0]    terms [bfp_pkg::N_PT],
  input  wire [bfp_pkg::N_PT-1:0]                     sub_mask,
  output logic signed [bfp_pkg::MAN_W+LOW_EXPAND+2:0] sum
);

  localparam int ACC_W = bfp_pkg::MAN_W + LOW_EXPAND + 3;

  logic signed [ACC_W+1:0] wide;  // two spare bits for the range check

  always_comb begin
    wide = '0;
    for (int p = 0; p < bfp_pkg::N_PT; p++) begin
      if (sub_mask[p]) begin
        wide = wide - (ACC_W+2)'(terms[p]);
      end else begin
        wide = wide + (ACC_W+2)'(terms[p]);
      end
    end
  end

  assign sum = wide[ACC_W-1:0];

  // four terms of guarded magnitude never carry past the accumulator
  sum_fits_acc: assert final (wide == (ACC_W+2)'(sum));

endmodule

`default_nettype wire

// File: logic/group_aligner.sv
// group_aligner: block exponent of one operand group and its aligned, signed mantissa terms
`timescale 1ns/1ps
`default_nettype none

module group_aligner #(
  parameter int LOW_EXPAND = bfp_pkg::LOW_EXPAND_DEF
) (
  input  wire bfp_pkg::sfp_t                      operands [bfp_pkg::N_PT],
  output logic [bfp_pkg::EXP_W-1:0]               max_exp,
  output logic signed [bfp_pkg::MAN_W+LOW_EXPAND:0] terms [bfp_pkg::N_PT]
);

  localparam int MAG_W = bfp_pkg::MAN_W + LOW_EXPAND;

  logic [MAG_W-1:0] mag [bfp_pkg::N_PT];

  always_comb begin
    max_exp = '0;
    for (int p = 0; p < bfp_pkg::N_PT; p++) begin
      if (operands[p].exp > max_exp) begin
        max_exp = operands[p].exp;
      end
    end
  end

  // guard bits first, then shift down to the block exponent
  always_comb begin
    for (int p = 0; p < bfp_pkg::N_PT; p++) begin
      mag[p] = (MAG_W'(operands[p].man) << LOW_EXPAND) >> (max_exp - operands[p].exp);
      if (operands[p].sign) begin
        terms[p] = -$signed({1'b0, mag[p]});
      end else begin
        terms[p] = $signed({1'b0, mag[p]});
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/bfp_stage_if.sv
// bfp_stage_if: one-cycle stage enables from the sequencer to the dft4 datapath
`timescale 1ns/1ps
`default_nettype none

interface bfp_stage_if;

  logic capture_en;  // load input samples
  logic align_en;    // load aligned terms and block exponents
  logic sum_en;      // load sums
  logic pack_en;     // load output words

  modport ctrl (
    output capture_en,
    output align_en,
    output sum_en,
    output pack_en
  );

  modport dp (
    input capture_en,
    input align_en,
    input sum_en,
    input pack_en
  );

endinterface

`default_nettype wire

// File: logic/bfp_pkg.sv
// bfp_pkg: sample format, controller states and operand routing tables of the dft4 engine
`default_nettype none

package bfp_pkg;

  localparam int EXP_W          = 4;
  localparam int MAN_W          = 4;
  localparam int WORD_W         = 9;
  localparam int N_PT           = 4;
  localparam int N_OUT          = 8;
  localparam int N_GRP          = 4;
  localparam int LOW_EXPAND_DEF = 2;

  // value is (-1)^sign * man * 2^exp
  typedef struct packed {
    logic             sign;
    logic [EXP_W-1:0] exp;
    logic [MAN_W-1:0] man;
  } sfp_t;

  typedef enum logic [2:0] {
    IDLE,
    ALIGN,
    SUM,
    PACK,
    DONE
  } dft_state_e;

  typedef struct packed {
    logic [$clog2(N_PT)-1:0] idx;
    logic                    imag;
  } operand_src_t;

  typedef struct packed {
    logic [$clog2(N_GRP)-1:0] grp;
    logic [N_PT-1:0]          sub;   // bit p set: term p subtracted
  } term_sign_t;

  // operand sources, [group][position]
  localparam operand_src_t GROUP_SEL [N_GRP][N_PT] = '{
    '{'{2'd0, 1'b0}, '{2'd1, 1'b0}, '{2'd2, 1'b0}, '{2'd3, 1'b0}},  // r0 r1 r2 r3
    '{'{2'd0, 1'b1}, '{2'd1, 1'b1}, '{2'd2, 1'b1}, '{2'd3, 1'b1}},  // i0 i1 i2 i3
    '{'{2'd0, 1'b0}, '{2'd1, 1'b1}, '{2'd2, 1'b0}, '{2'd3, 1'b1}},  // r0 i1 r2 i3
    '{'{2'd0, 1'b1}, '{2'd1, 1'b0}, '{2'd2, 1'b1}, '{2'd3, 1'b0}}   // i0 r1 i2 r3
  };

  // outputs 0..3 are Re X0..X3, outputs 4..7 are Im X0..X3
  localparam term_sign_t TERM_SIGN [N_OUT] = '{
    '{2'd0, 4'b0000},  // r0+r1+r2+r3
    '{2'd2, 4'b1100},  // r0+i1-r2-i3
    '{2'd0, 4'b1010},  // r0-r1+r2-r3
    '{2'd2, 4'b0110},  // r0-i1-r2+i3
    '{2'd1, 4'b0000},  // i0+i1+i2+i3
    '{2'd3, 4'b0110},  // i0-r1-i2+r3
    '{2'd1, 4'b1010},  // i0-i1+i2-i3
    '{2'd3, 4'b1100}   // i0+r1-i2-r3
  };

endpackage

`default_nettype wire
